// File: include/tcore_defines.svh
// Memory map and width macros for the data-side peripheral block
// Region bases, address masks and data RAM depth

`ifndef TCORE_DEFINES_SVH
`define TCORE_DEFINES_SVH

// Address and data width of the core bus
`define XLEN 32

// Main memory, 1 MiB window
`define RAM_BASE 32'h4000_0000
`define RAM_MASK 32'h000F_FFFF

// External UART, 16 bytes of registers
`define UART_BASE 32'h2000_0000
`define UART_MASK 32'h0000_000F

// Machine timer, mtime and mtimecmp
`define TIMER_BASE 32'h3000_0000
`define TIMER_MASK 32'h0000_0007

// Data RAM words, index taken from address bits 9 to 2
`define RAM_WORDS 256

`endif

// File: logic/tcore_map_pkg.sv
// Memory map types
// Region enum, PMA attribute struct and the two-view address union

`include "tcore_defines.svh"

package tcore_map_pkg;

  // Field widths of the address views
  localparam int RAM_IDX_W = $clog2(`RAM_WORDS);
  localparam int IO_OFF_W  = $clog2(`TIMER_MASK + 1);

  // Region selected by the PMA decode
  typedef enum logic [1:0] {
    REGION_NONE  = 2'd0,
    REGION_RAM   = 2'd1,
    REGION_UART  = 2'd2,
    REGION_TIMER = 2'd3
  } region_e;

  // Attributes reported back to the core
  typedef struct packed {
    logic uncached;
    logic memregion;
  } pma_attr_t;

  // Same address word seen by the RAM and by the IO registers
  typedef union packed {
    struct packed {
      logic [`XLEN-RAM_IDX_W-3:0] tag;
      logic [RAM_IDX_W-1:0]       word;
      logic [1:0]                 byte_off;
    } ram;
    struct packed {
      logic [`XLEN-IO_OFF_W-1:0]  tag;
      logic [IO_OFF_W-1:0]        offset;
    } io;
  } pma_addr_u;

endpackage

// File: logic/tcore_bus_pkg.sv
// Bus types
// APB data word and machine timer register offsets

`include "tcore_defines.svh"

package tcore_bus_pkg;

  // One APB data beat
  typedef logic [`XLEN-1:0] apb_word_t;

  // Timer register map, byte offsets inside the timer window
  typedef enum logic [2:0] {
    MTIME    = 3'h0,
    MTIMECMP = 3'h4
  } timer_reg_e;

endpackage

// File: logic/apb_if.sv
// APB interface between the fabric and its targets
// Master and slave modports

`timescale 1ns/1ps
`include "tcore_defines.svh"

interface apb_if;
  import tcore_bus_pkg::*;

  // Request side
  logic             psel;
  logic             penable;
  logic             pwrite;
  logic [`XLEN-1:0] paddr;
  apb_word_t        pwdata;

  // Response side
  apb_word_t        prdata;
  logic             pready;
  logic             pslverr;

  modport master (
    output psel, penable, pwrite, paddr, pwdata,
    input  prdata, pready, pslverr
  );

  modport slave (
    input  psel, penable, pwrite, paddr, pwdata,
    output prdata, pready, pslverr
  );

endinterface

// File: logic/pma.sv
// Physical memory attribute checker
// Address to region and attribute decode, first match wins

`timescale 1ns/1ps
`include "tcore_defines.svh"

module pma (
  input  logic [`XLEN-1:0]        addr_i,
  output tcore_map_pkg::region_e   region_o,
  output tcore_map_pkg::pma_attr_t attr_o
);
  import tcore_map_pkg::*;

  logic hit_ram;
  logic hit_uart;
  logic hit_timer;

  // Strip the in-region offset and compare against the base
  assign hit_ram   = (addr_i & ~`RAM_MASK)   == `RAM_BASE;
  assign hit_uart  = (addr_i & ~`UART_MASK)  == `UART_BASE;
  assign hit_timer = (addr_i & ~`TIMER_MASK) == `TIMER_BASE;

  always_comb begin
    // Unmapped by default, both attributes low
    region_o = REGION_NONE;
    attr_o   = '0;
    // Priority RAM, UART, timer
    if (hit_ram) begin
      region_o         = REGION_RAM;
      attr_o.uncached  = 1'b0;
      attr_o.memregion = 1'b1;
    end else if (hit_uart) begin
      region_o         = REGION_UART;
      attr_o.uncached  = 1'b0;
      attr_o.memregion = 1'b0;
    end else if (hit_timer) begin
      // Timer registers change on their own, never cache them
      region_o         = REGION_TIMER;
      attr_o.uncached  = 1'b1;
      attr_o.memregion = 1'b1;
    end
  end

endmodule

// File: logic/apb_fabric.sv
// APB fabric for the core data port
// Region routing, unmapped error response and fault address capture

`timescale 1ns/1ps
`include "tcore_defines.svh"

module apb_fabric (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Core slave port
  input  logic                      psel_i,
  input  logic                      penable_i,
  input  logic                      pwrite_i,
  input  logic [`XLEN-1:0]          paddr_i,
  input  tcore_bus_pkg::apb_word_t  pwdata_i,
  output tcore_bus_pkg::apb_word_t  prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,
  // Attributes and fault report
  output tcore_map_pkg::pma_attr_t  attr_o,
  output logic [`XLEN-1:0]          fault_addr_o,
  output logic                      fault_valid_o,
  // Internal targets
  apb_if.master                     ram_bus,
  apb_if.master                     timer_bus,
  // External UART master port
  output logic                      uart_psel_o,
  output logic                      uart_penable_o,
  output logic                      uart_pwrite_o,
  output logic [`XLEN-1:0]          uart_paddr_o,
  output tcore_bus_pkg::apb_word_t  uart_pwdata_o,
  input  tcore_bus_pkg::apb_word_t  uart_prdata_i,
  input  logic                      uart_pready_i,
  input  logic                      uart_pslverr_i
);
  import tcore_map_pkg::*;

  region_e region;
  logic    access;

  pma u_pma (
    .addr_i   (paddr_i),
    .region_o (region),
    .attr_o   (attr_o)
  );

  ////////////////////////////////////////
  // Request side
  ////////////////////////////////////////

  // One select per target, none when unmapped
  assign ram_bus.psel   = psel_i && (region == REGION_RAM);
  assign timer_bus.psel = psel_i && (region == REGION_TIMER);
  assign uart_psel_o    = psel_i && (region == REGION_UART);

  // Shared request fields fan out unchanged
  assign ram_bus.penable   = penable_i;
  assign ram_bus.pwrite    = pwrite_i;
  assign ram_bus.paddr     = paddr_i;
  assign ram_bus.pwdata    = pwdata_i;
  assign timer_bus.penable = penable_i;
  assign timer_bus.pwrite  = pwrite_i;
  assign timer_bus.paddr   = paddr_i;
  assign timer_bus.pwdata  = pwdata_i;
  assign uart_penable_o    = penable_i;
  assign uart_pwrite_o     = pwrite_i;
  assign uart_paddr_o      = paddr_i;
  assign uart_pwdata_o     = pwdata_i;

  ////////////////////////////////////////
  // Response side
  ////////////////////////////////////////

  assign access = psel_i && penable_i;

  always_comb begin
    // Unmapped, answer with an error in the first access cycle
    prdata_o  = '0;
    pready_o  = access;
    pslverr_o = access;
    case (region)
      REGION_RAM: begin
        prdata_o  = ram_bus.prdata;
        pready_o  = ram_bus.pready;
        pslverr_o = ram_bus.pslverr;
      end
      REGION_TIMER: begin
        prdata_o  = timer_bus.prdata;
        pready_o  = timer_bus.pready;
        pslverr_o = timer_bus.pslverr;
      end
      REGION_UART: begin
        // Wait states from the UART reach the core as they are
        prdata_o  = uart_prdata_i;
        pready_o  = uart_pready_i;
        pslverr_o = uart_pslverr_i;
      end
      default: ;
    endcase
  end

  // Sticky fault record, cleared by reset only
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fault_addr_o  <= '0;
      fault_valid_o <= 1'b0;
    end else if (access && (region == REGION_NONE)) begin
      fault_addr_o  <= paddr_i;
      fault_valid_o <= 1'b1;
    end
  end

endmodule

// File: logic/data_ram.sv
// On-chip data RAM behind an APB slave port
// Zero wait states, word index from the RAM view of the address

`timescale 1ns/1ps
`include "tcore_defines.svh"

module data_ram (
  input logic  clk_i,
  apb_if.slave bus
);
  import tcore_map_pkg::*;
  import tcore_bus_pkg::*;

  apb_word_t mem [`RAM_WORDS];
  pma_addr_u addr;
  logic      access;

  // Upper region bits ignored, contents alias every 1 KiB
  assign addr   = bus.paddr;
  assign access = bus.psel && bus.penable;

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // Write lands at the end of the access cycle
  always_ff @(posedge clk_i) begin
    if (access && bus.pwrite) begin
      mem[addr.ram.word] <= bus.pwdata;
    end
  end

  ////////////////////////////////////////
  // APB response
  ////////////////////////////////////////

  // Asynchronous read so data is ready in the first access cycle
  assign bus.prdata  = (bus.psel && !bus.pwrite) ? mem[addr.ram.word] : '0;
  // Never stalls
  assign bus.pready  = access;
  // Every word in the window exists
  assign bus.pslverr = 1'b0;

endmodule

// File: logic/mtimer.sv
// Machine timer with an APB slave port
// mtime, mtimecmp and the timer interrupt

`timescale 1ns/1ps

module mtimer (
  input  logic clk_i,
  input  logic rst_n_i,
  apb_if.slave bus,
  output logic irq_o
);
  import tcore_map_pkg::*;
  import tcore_bus_pkg::*;

  apb_word_t mtime;
  apb_word_t mtimecmp;
  pma_addr_u addr;
  logic      wr_en;

  assign addr  = bus.paddr;
  assign wr_en = bus.psel && bus.penable && bus.pwrite;

  ////////////////////////////////////////
  // Counter and compare registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtime    <= '0;
      // All ones keeps the interrupt quiet out of reset
      mtimecmp <= '1;
    end else begin
      // A write to mtime replaces this cycle's increment
      if (wr_en && (addr.io.offset == MTIME)) begin
        mtime <= bus.pwdata;
      end else begin
        mtime <= mtime + 32'd1;
      end
      if (wr_en && (addr.io.offset == MTIMECMP)) begin
        mtimecmp <= bus.pwdata;
      end
    end
  end

  // Read mux with holes in the map returning zero
  always_comb begin
    case (addr.io.offset)
      MTIME:    bus.prdata = mtime;
      MTIMECMP: bus.prdata = mtimecmp;
      default:  bus.prdata = '0;
    endcase
  end

  assign bus.pready  = bus.psel && bus.penable;
  assign bus.pslverr = 1'b0;

  // Level interrupt that stays up until software moves mtimecmp
  assign irq_o = (mtime >= mtimecmp);

endmodule

// File: logic/tcore_mem_top.sv
// Top level of the data-side address decode block
// Fabric, data RAM and machine timer wired together

`timescale 1ns/1ps
`include "tcore_defines.svh"

module tcore_mem_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Core APB slave port
  input  logic                     psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  logic [`XLEN-1:0]         paddr_i,
  input  tcore_bus_pkg::apb_word_t pwdata_i,
  output tcore_bus_pkg::apb_word_t prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o,
  // External UART APB master port
  output logic                     uart_psel_o,
  output logic                     uart_penable_o,
  output logic                     uart_pwrite_o,
  output logic [`XLEN-1:0]         uart_paddr_o,
  output tcore_bus_pkg::apb_word_t uart_pwdata_o,
  input  tcore_bus_pkg::apb_word_t uart_prdata_i,
  input  logic                     uart_pready_i,
  input  logic                     uart_pslverr_i,
  // Status
  output logic                     pma_uncached_o,
  output logic                     pma_memregion_o,
  output logic [`XLEN-1:0]         fault_addr_o,
  output logic                     fault_valid_o,
  output logic                     timer_irq_o
);
  import tcore_map_pkg::*;

  pma_attr_t attr;
  apb_if     ram_bus ();
  apb_if     timer_bus ();

  // Attribute struct split into the two core-facing bits
  assign pma_uncached_o  = attr.uncached;
  assign pma_memregion_o = attr.memregion;

  apb_fabric u_fabric (
    .clk_i, .rst_n_i,
    .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .attr_o (attr), .fault_addr_o, .fault_valid_o,
    .ram_bus (ram_bus.master), .timer_bus (timer_bus.master),
    .uart_psel_o, .uart_penable_o, .uart_pwrite_o, .uart_paddr_o, .uart_pwdata_o,
    .uart_prdata_i, .uart_pready_i, .uart_pslverr_i
  );

  data_ram u_ram (.clk_i, .bus (ram_bus.slave));

  mtimer u_timer (.clk_i, .rst_n_i, .bus (timer_bus.slave), .irq_o (timer_irq_o));

endmodule

// File: tb/tcore_mem_props.sv
// Concurrent checks on the fabric's APB behavior
// Bound into every apb_fabric instance

`timescale 1ns/1ps

module tcore_mem_props (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic                   psel_i,
  input logic                   penable_i,
  input logic                   pready_i,
  input logic                   pslverr_i,
  input logic                   ram_psel_i,
  input logic                   timer_psel_i,
  input logic                   uart_psel_i,
  input tcore_map_pkg::region_e region_i
);
  import tcore_map_pkg::*;

  // Never more than one target selected
  a_one_sel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({ram_psel_i, timer_psel_i, uart_psel_i}))
    else $error("more than one downstream psel is high");

  // Core only sees pready inside a transfer
  a_ready_in_sel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pready_i |-> psel_i)
    else $error("pready is high while psel is low");

  // Unmapped access cycle ends with an error
  a_unmapped_err: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (psel_i && penable_i && (region_i == REGION_NONE)) |-> (pready_i && pslverr_i))
    else $error("unmapped access cycle without pslverr");

endmodule

bind apb_fabric tcore_mem_props u_props (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .psel_i       (psel_i),
  .penable_i    (penable_i),
  .pready_i     (pready_o),
  .pslverr_i    (pslverr_o),
  .ram_psel_i   (ram_bus.psel),
  .timer_psel_i (timer_bus.psel),
  .uart_psel_i  (uart_psel_o),
  .region_i     (region)
);

// File: tb/tcore_mem_tb.sv
// Testbench for the data-side address decode block
// Clock, reset, UART responder, stimulus table and compare tasks

`timescale 1ns/1ps
`include "tcore_defines.svh"

module tcore_mem_tb;
  import tcore_map_pkg::*;
  import tcore_bus_pkg::*;

  // Table row with rdata checked only on error-free reads
  typedef struct {
    logic [`XLEN-1:0] addr;
    bit               wr;
    apb_word_t        wdata;
    apb_word_t        rdata;
    bit               err;
    pma_attr_t        attr;
  } entry_t;

  // Expected attributes per region
  localparam pma_attr_t attr_ram   = '{uncached: 1'b0, memregion: 1'b1};
  localparam pma_attr_t attr_timer = '{uncached: 1'b1, memregion: 1'b1};
  localparam pma_attr_t attr_none  = '{uncached: 1'b0, memregion: 1'b0};
  localparam int        max_wait   = 20;

  logic             clk;
  logic             rst_n;
  logic             psel;
  logic             penable;
  logic             pwrite;
  logic [`XLEN-1:0] paddr;
  apb_word_t        pwdata;
  apb_word_t        prdata;
  logic             pready;
  logic             pslverr;
  logic             uart_psel;
  logic             uart_penable;
  logic             uart_pwrite;
  logic [`XLEN-1:0] uart_paddr;
  apb_word_t        uart_pwdata;
  apb_word_t        uart_prdata;
  logic             uart_pready;
  logic             uart_pslverr;
  logic             pma_uncached;
  logic             pma_memregion;
  logic [`XLEN-1:0] fault_addr;
  logic             fault_valid;
  logic             timer_irq;
  apb_word_t        uart_reg;
  int               uart_wait;
  entry_t           tbl [$];

  tcore_mem_top DUT (
    .clk_i (clk), .rst_n_i (rst_n),
    .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite),
    .paddr_i (paddr), .pwdata_i (pwdata),
    .prdata_o (prdata), .pready_o (pready), .pslverr_o (pslverr),
    .uart_psel_o (uart_psel), .uart_penable_o (uart_penable),
    .uart_pwrite_o (uart_pwrite), .uart_paddr_o (uart_paddr),
    .uart_pwdata_o (uart_pwdata), .uart_prdata_i (uart_prdata),
    .uart_pready_i (uart_pready), .uart_pslverr_i (uart_pslverr),
    .pma_uncached_o (pma_uncached), .pma_memregion_o (pma_memregion),
    .fault_addr_o (fault_addr), .fault_valid_o (fault_valid),
    .timer_irq_o (timer_irq)
  );

  // 4 ns clock
  always #2 clk = ~clk;

  ////////////////////////////////////////
  // UART responder with one register
  ////////////////////////////////////////

  // Random 0 to 2 wait states loaded in the setup cycle
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      uart_wait <= 0;
      uart_reg  <= '0;
    end else if (uart_psel && !uart_penable) begin
      // Core address reaches the UART port unchanged
      check_word("uart_paddr_o", uart_paddr, paddr);
      uart_wait <= $urandom_range(2, 0);
    end else if (uart_psel && uart_penable) begin
      if (uart_wait != 0) begin
        uart_wait <= uart_wait - 1;
      end else if (uart_pwrite) begin
        uart_reg <= uart_pwdata;
      end
    end
  end

  assign uart_pready  = uart_psel && uart_penable && (uart_wait == 0);
  assign uart_prdata  = uart_reg;
  assign uart_pslverr = 1'b0;

  ////////////////////////////////////////
  // Helpers and compare tasks
  ////////////////////////////////////////

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input string name, input apb_word_t got, input apb_word_t exp);
    if (got !== exp) begin
      $display("** Error @%0t ns: %s = %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_attr(input string name, input pma_attr_t got, input pma_attr_t exp);
    if (got !== exp) begin
      $display("** Error @%0t ns: %s = %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error @%0t ns: %s = %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  function automatic void add_entry(input logic [`XLEN-1:0] addr, input bit wr,
                                    input apb_word_t wdata, input apb_word_t rdata,
                                    input bit err, input pma_attr_t attr);
    entry_t e;
    e = '{addr: addr, wr: wr, wdata: wdata, rdata: rdata, err: err, attr: attr};
    tbl.push_back(e);
  endfunction

  // One APB transfer with the response sampled on the falling edge
  task automatic apb_xfer(input logic [`XLEN-1:0] addr, input bit wr, input apb_word_t wdata,
                          output apb_word_t rdata, output logic err, output pma_attr_t attr);
    int cycles;
    cycles = 0;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (!pready) begin
      cycles++;
      if (cycles > max_wait) begin
        $display("Timeout: no pready for address %h after %0d cycles", addr, max_wait);
        abort_run();
      end
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    attr  = '{uncached: pma_uncached, memregion: pma_memregion};
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    apb_word_t rdata;
    logic      err;
    pma_attr_t attr;
    apb_word_t ram_a;
    apb_word_t ram_b;
    apb_word_t ram_c;
    apb_word_t uart_v;
    apb_word_t v;
    void'($urandom(32'ha92b_a4a5));
    clk     = 1'b0;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    ram_a   = $urandom;
    ram_b   = $urandom;
    ram_c   = $urandom;
    uart_v  = $urandom;

    // RAM writes and read back plus a 1 KiB alias of the second word
    add_entry(`RAM_BASE, 1'b1, ram_a, '0, 1'b0, attr_ram);
    add_entry(`RAM_BASE + 32'h10, 1'b1, ram_b, '0, 1'b0, attr_ram);
    add_entry(`RAM_BASE + 32'hF_FFFC, 1'b1, ram_c, '0, 1'b0, attr_ram);
    add_entry(`RAM_BASE, 1'b0, '0, ram_a, 1'b0, attr_ram);
    add_entry(`RAM_BASE + 32'h10, 1'b0, '0, ram_b, 1'b0, attr_ram);
    add_entry(`RAM_BASE + 32'h410, 1'b0, '0, ram_b, 1'b0, attr_ram);
    add_entry(`RAM_BASE + 32'hF_FFFC, 1'b0, '0, ram_c, 1'b0, attr_ram);
    // UART through the responder
    add_entry(`UART_BASE + 32'h4, 1'b1, uart_v, '0, 1'b0, attr_none);
    add_entry(`UART_BASE + 32'h4, 1'b0, '0, uart_v, 1'b0, attr_none);
    // mtimecmp out of reset
    add_entry(`TIMER_BASE + 32'h4, 1'b0, '0, 32'hFFFF_FFFF, 1'b0, attr_timer);
    // One byte past each window and then a plain unmapped write
    add_entry(`RAM_BASE + `RAM_MASK + 32'h1, 1'b0, '0, '0, 1'b1, attr_none);
    add_entry(`UART_BASE + `UART_MASK + 32'h1, 1'b0, '0, '0, 1'b1, attr_none);
    add_entry(`TIMER_BASE + `TIMER_MASK + 32'h1, 1'b0, '0, '0, 1'b1, attr_none);
    add_entry(32'h7000_1234, 1'b1, 32'hDEAD_BEEF, '0, 1'b1, attr_none);

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    foreach (tbl[i]) begin
      apb_xfer(tbl[i].addr, tbl[i].wr, tbl[i].wdata, rdata, err, attr);
      if (!tbl[i].wr && !tbl[i].err) begin
        check_word("prdata_o", rdata, tbl[i].rdata);
      end
      check_bit("pslverr_o", err, tbl[i].err);
      check_attr("pma attributes", attr, tbl[i].attr);
    end

    // Fault record holds the last unmapped address
    @(negedge clk);
    check_word("fault_addr_o", fault_addr, 32'h7000_1234);
    check_bit("fault_valid_o", fault_valid, 1'b1);
    check_bit("timer_irq_o", timer_irq, 1'b0);

    // mtimecmp of zero fires at once
    apb_xfer(`TIMER_BASE + 32'h4, 1'b1, '0, rdata, err, attr);
    @(negedge clk);
    check_bit("timer_irq_o", timer_irq, 1'b1);
    apb_xfer(`TIMER_BASE, 1'b1, '0, rdata, err, attr);
    apb_xfer(`TIMER_BASE + 32'h4, 1'b1, 32'hFFFF_0000, rdata, err, attr);
    @(negedge clk);
    check_bit("timer_irq_o", timer_irq, 1'b0);

    // Counter keeps running after a load
    v = $urandom & 32'h0FFF_FFFF;
    apb_xfer(`TIMER_BASE, 1'b1, v, rdata, err, attr);
    apb_xfer(`TIMER_BASE, 1'b0, '0, rdata, err, attr);
    if (rdata < v || rdata > v + 32'd10) begin
      $display("** Error @%0t ns: mtime = %h, expected %h to %h", $time, rdata, v, v + 32'd10);
      abort_run();
    end

    // Valid accesses leave the fault record alone
    check_bit("fault_valid_o", fault_valid, 1'b1);
    check_word("fault_addr_o", fault_addr, 32'h7000_1234);

    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: project.f
+incdir+include
logic/tcore_map_pkg.sv
logic/tcore_bus_pkg.sv
logic/apb_if.sv
logic/pma.sv
logic/apb_fabric.sv
logic/data_ram.sv
logic/mtimer.sv
logic/tcore_mem_top.sv
tb/tcore_mem_props.sv
tb/tcore_mem_tb.sv

// File: Makefile
# Verilator flow for the data-side address decode block

VERILATOR ?= verilator
TOP       ?= tcore_mem_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
